// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int DATA_W      = 16;                // data word width
    localparam int ADDR_W      = 11;                // microcode address width
    localparam int MEM_DEPTH   = 2048;              // microcode words
    localparam int STACK_DEPTH = 16;                // default cells per stack

    localparam logic [3:0] DEV_OUT_REG = 4'h0;      // parallel output register
    localparam logic [3:0] DEV_IN_REG  = 4'h1;      // synchronized input register

    typedef logic [DATA_W-1:0] word_t;              // one data word
    typedef logic [ADDR_W-1:0] uaddr_t;             // one microcode address

    localparam word_t WORD_ONE  = 16'h0001;         // right operand constants
    localparam word_t WORD_MSB  = 16'h8000;
    localparam word_t WORD_ONES = 16'hFFFF;
    localparam word_t UC_NOP    = 16'h0000;         // instruction held after reset

    // stack effects, top of stack on the right
    typedef enum logic [2:0] {
        ST_NONE = 3'd0,                             // ( -- )
        ST_DROP = 3'd1,                             // ( a -- )
        ST_PUSH = 3'd2,                             // ( -- v )
        ST_RPLC = 3'd3,                             // ( a -- v )
        ST_SWAP = 3'd4,                             // ( a b -- b a )
        ST_ROT  = 3'd5,                             // ( a b c -- b c a )
        ST_OVER = 3'd6,                             // ( a b -- a b a )
        ST_DRPL = 3'd7                              // ( a b -- v ) for binary ALU ops
    } stack_op_e;

    typedef enum logic [3:0] {
        ALU_PASS = 4'h0,                            // left operand
        ALU_ADD  = 4'h1,
        ALU_SUB  = 4'h2,                            // left minus right
        ALU_AND  = 4'h4,
        ALU_XOR  = 4'h5,
        ALU_OR   = 4'h6,
        ALU_ROL  = 4'h7,                            // left rotated by one
        ALU_MEM  = 4'hF                             // memory op, ALU bypassed
    } alu_op_e;

    // left: top, second, return top, zero
    // right: top, one, 0x8000, all-ones
    typedef enum logic [1:0] {
        SEL_0 = 2'd0,
        SEL_1 = 2'd1,
        SEL_2 = 2'd2,
        SEL_3 = 2'd3
    } alu_sel_e;

    typedef enum logic [2:0] {
        RNG_UCODE = 3'd0,                           // microcode read/write at top
        RNG_PC    = 3'd1,                           // inline literal at pc, pc skips it
        RNG_FAIL  = 3'd2,                           // clears status
        RNG_DEV   = 3'd3                            // device registers, 4..7 do nothing
    } mem_rng_e;

    typedef struct packed {
        logic      ctrl;                            // 1 = control transfer
        logic      r_pc;                            // call or return
        logic [1:0] r_op;                           // return stack op / branch kind
        logic      d_drop;                          // extra drop in ALU phase
        stack_op_e d_op;
        alu_sel_e  alu_a;                           // mem op: {wr, rng[2]}
        alu_sel_e  alu_b;                           // mem op: rng[1:0]
        alu_op_e   alu_op;
    } instr_t;

    typedef struct packed {
        logic  en;                                  // single-cycle strobe
        logic  wr;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== ucode_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucode_mem import cpu_pkg::*; (
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_load,                   // external load strobe
    input  wire uaddr_t   i_load_addr,
    input  wire word_t    i_load_data,
    input  wire           i_running,                // loads only while stopped
    input  wire uaddr_t   i_pc,                     // default read address
    input  wire mem_req_t i_req,                    // processor access
    output word_t         o_rdata                   // registered read data
);

    word_t  mem [MEM_DEPTH];                        // inferred block ram
    uaddr_t rd_addr;
    logic   load_ok;

    assign load_ok = i_load && !i_running;
    assign rd_addr = i_req.en ? i_req.addr[ADDR_W-1:0] : i_pc;  // fetch at pc otherwise

    always_ff @(posedge i_clk) begin
        if (load_ok) begin
            mem[i_load_addr] <= i_load_data;        // load port wins
        end else if (i_req.en && i_req.wr) begin
            mem[i_req.addr[ADDR_W-1:0]] <= i_req.wdata;
        end else begin
            o_rdata <= mem[rd_addr];                // no read on a write cycle
        end
    end

    // programs go in only while the engine is stopped
    a_load_stopped: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_load |-> !i_running
    ) else $error("ucode load while running");

endmodule

`default_nettype wire

// ==== stack_lifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_lifo import cpu_pkg::*; #(
    parameter int DEPTH = STACK_DEPTH               // at least 3 for rot
) (
    input  wire            i_clk,
    input  wire            i_rst_n,
    input  wire word_t     i_value,                 // value for push/replace
    input  wire stack_op_e i_op,
    output word_t          o_s0,                    // top
    output word_t          o_s1                     // second
);

    word_t cells [DEPTH];                           // cells[0] is the top

    assign o_s0 = cells[0];
    assign o_s1 = cells[1];

    always_ff @(posedge i_clk) begin
        case (i_op)
            ST_DROP: begin
                for (int i = 0; i < DEPTH - 1; i++) cells[i] <= cells[i+1];
            end
            ST_PUSH: begin
                cells[0] <= i_value;
                for (int i = 1; i < DEPTH; i++) cells[i] <= cells[i-1];
            end
            ST_RPLC: cells[0] <= i_value;
            ST_SWAP: begin
                cells[0] <= cells[1];
                cells[1] <= cells[0];
            end
            ST_ROT: begin
                cells[0] <= cells[2];               // third comes up
                cells[1] <= cells[0];
                cells[2] <= cells[1];
            end
            ST_OVER: begin
                cells[0] <= cells[1];               // copy of second on top
                for (int i = 1; i < DEPTH; i++) cells[i] <= cells[i-1];
            end
            ST_DRPL: begin
                cells[0] <= i_value;                // two operands become one result
                for (int i = 1; i < DEPTH - 1; i++) cells[i] <= cells[i+1];
            end
            default: ;                              // none
        endcase
    end

    a_op_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !$isunknown(i_op)
    ) else $error("undefined stack op");

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire alu_op_e  i_op,
    input  wire alu_sel_e i_sel_a,                  // left operand select
    input  wire alu_sel_e i_sel_b,                  // right operand select
    input  wire word_t    i_d0,                     // data top
    input  wire word_t    i_d1,                     // data second
    input  wire word_t    i_r0,                     // return top
    output word_t         o_result
);

    word_t arg_a;
    word_t arg_b;

    always_comb begin
        case (i_sel_a)
            SEL_0:   arg_a = i_d0;
            SEL_1:   arg_a = i_d1;
            SEL_2:   arg_a = i_r0;
            default: arg_a = '0;                    // zero, used by negate
        endcase
    end

    always_comb begin
        case (i_sel_b)
            SEL_0:   arg_b = i_d0;
            SEL_1:   arg_b = WORD_ONE;
            SEL_2:   arg_b = WORD_MSB;
            default: arg_b = WORD_ONES;             // -1, also invert via xor
        endcase
    end

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = arg_a + arg_b;
            ALU_SUB: o_result = arg_a - arg_b;
            ALU_AND: o_result = arg_a & arg_b;
            ALU_XOR: o_result = arg_a ^ arg_b;
            ALU_OR:  o_result = arg_a | arg_b;
            ALU_ROL: o_result = {arg_a[DATA_W-2:0], arg_a[DATA_W-1]};  // msb wraps to bit 0
            default: o_result = arg_a;              // pass, mem ops unused
        endcase
    end

endmodule

`default_nettype wire

// ==== uc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module uc_engine import cpu_pkg::*; (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_run,
    input  wire word_t i_rdata,                     // ucode word, registered in memory
    input  wire word_t i_dev_rdata,
    input  wire word_t i_d0,
    input  wire word_t i_d1,
    input  wire word_t i_r0,
    input  wire word_t i_alu_result,
    output uaddr_t     o_pc,
    output mem_req_t   o_mem_req,
    output mem_req_t   o_dev_req,
    output word_t      o_d_value,
    output word_t      o_r_value,
    output stack_op_e  o_d_op,
    output stack_op_e  o_r_op,
    output alu_op_e    o_alu_op,
    output alu_sel_e   o_sel_a,
    output alu_sel_e   o_sel_b,
    output logic       o_running,
    output logic       o_status
);

    logic     phase_alu;                            // 0 stack phase, 1 ALU phase
    logic     status;
    uaddr_t   pc;
    word_t    instr_r;                              // latched instruction
    word_t    instr_w;                              // raw current word
    instr_t   ins;
    logic     is_mem;
    logic     mem_wr;
    mem_rng_e mem_rng;
    logic     d_zero;
    logic     take_fail;
    word_t    d_value;

    // ALU phase decodes the word straight out of memory
    assign instr_w   = phase_alu ? i_rdata : instr_r;
    assign ins       = instr_t'(instr_w);
    assign is_mem    = !ins.ctrl && (ins.alu_op == ALU_MEM);
    assign mem_wr    = instr_w[7];
    assign mem_rng   = mem_rng_e'(instr_w[6:4]);
    assign d_zero    = (i_d0 == '0);
    assign take_fail = phase_alu && is_mem && (mem_rng == RNG_FAIL);

    assign o_running = i_run && status;
    assign o_status  = status;
    assign o_pc      = pc;

    assign o_mem_req = '{
        en:    phase_alu && is_mem && (mem_rng == RNG_UCODE),
        wr:    mem_wr,
        addr:  i_d0,                                // address on top
        wdata: i_d1                                 // ( value addr -- )
    };
    assign o_dev_req = '{
        en:    phase_alu && is_mem && (mem_rng == RNG_DEV),
        wr:    mem_wr,
        addr:  i_d0,
        wdata: i_d1
    };

    // control ops add -1 or 1 to the top for count-down
    assign o_alu_op = ins.ctrl ? ALU_ADD : ins.alu_op;
    assign o_sel_a  = ins.ctrl ? SEL_0 : ins.alu_a;
    assign o_sel_b  = ins.ctrl ? alu_sel_e'(ins.r_op) : ins.alu_b;

    always_comb begin
        if (is_mem && (mem_rng == RNG_UCODE || mem_rng == RNG_PC)) begin
            d_value = i_rdata;                      // fetched word or literal
        end else if (is_mem && mem_rng == RNG_DEV) begin
            d_value = i_dev_rdata;
        end else begin
            d_value = i_alu_result;
        end
    end
    assign o_d_value = d_value;
    assign o_r_value = ins.ctrl ? word_t'(pc) : d_value;  // return address on call

    always_comb begin
        o_d_op = ST_NONE;
        o_r_op = ST_NONE;
        if (phase_alu) begin
            if (!ins.ctrl && ins.d_drop) o_d_op = ST_DROP;     // store consumes address
            if (ins.ctrl && ins.r_pc) o_r_op = ST_PUSH;        // call
        end else if (o_running) begin
            if (!ins.ctrl) begin
                o_d_op = ins.d_op;
                o_r_op = stack_op_e'({1'b0, ins.r_op});
            end else if (ins.r_op == 2'b10) begin
                o_d_op = ST_DROP;                   // branch-if-zero pops its test
            end else if (ins.r_op != 2'b00) begin
                o_d_op = d_zero ? ST_DROP : ST_RPLC;  // count-down
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase_alu <= 1'b0;
            status    <= 1'b1;                      // success until a fail access
            pc        <= '0;
            instr_r   <= UC_NOP;
        end else if (phase_alu) begin
            if (take_fail) status <= 1'b0;
            if (!ins.ctrl && ins.r_pc) begin
                pc <= i_r0[ADDR_W-1:0];             // return
            end else if (is_mem && mem_rng == RNG_PC) begin
                pc <= pc + 1'b1;                    // skip inline literal
            end else if (ins.ctrl && (ins.r_op == 2'b00 || d_zero)) begin
                pc <= instr_w[ADDR_W-1:0];          // jump, call or taken branch
            end
            instr_r   <= i_rdata;
            phase_alu <= 1'b0;
        end else if (o_running) begin
            pc        <= pc + 1'b1;                 // next word being fetched
            phase_alu <= 1'b1;
        end
    end

    // ucode and device never share one access
    a_one_target: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(o_mem_req.en && o_dev_req.en)
    ) else $error("ucode and device request together");

endmodule

`default_nettype wire

// ==== dev_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module dev_port import cpu_pkg::*; (
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire mem_req_t i_req,                    // register id in addr[3:0]
    input  wire word_t    i_in_data,                // asynchronous input word
    output word_t         o_rdata,
    output logic          o_out_valid,              // one cycle per write
    output word_t         o_out_data
);

    word_t      sync_q1;
    word_t      sync_q2;
    logic [3:0] reg_id;
    logic       wr_out;

    assign reg_id  = i_req.addr[3:0];
    assign wr_out  = i_req.en && i_req.wr && (reg_id == DEV_OUT_REG);
    assign o_rdata = (reg_id == DEV_IN_REG) ? sync_q2 : '0;  // unknown ids read zero

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q1     <= '0;
            sync_q2     <= '0;
            o_out_valid <= 1'b0;
        end else begin
            sync_q1     <= i_in_data;               // two-stage sync
            sync_q2     <= sync_q1;
            o_out_valid <= wr_out;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_out) o_out_data <= i_req.wdata;      // held until next write
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire         i_run,
    input  wire         i_load,
    input  wire uaddr_t i_load_addr,
    input  wire word_t  i_load_data,
    input  wire word_t  i_in_data,
    output logic        o_running,
    output logic        o_status,
    output logic        o_out_valid,
    output word_t       o_out_data
);

    uaddr_t    pc;
    mem_req_t  mem_req;
    mem_req_t  dev_req;
    word_t     rdata;
    word_t     dev_rdata;
    word_t     d_value;
    word_t     r_value;
    stack_op_e d_op;
    stack_op_e r_op;
    word_t     d0;
    word_t     d1;
    word_t     r0;
    alu_op_e   alu_op;
    alu_sel_e  sel_a;
    alu_sel_e  sel_b;
    word_t     alu_result;

    ucode_mem UCODE (.i_clk, .i_rst_n, .i_load, .i_load_addr, .i_load_data,
        .i_running(o_running), .i_pc(pc), .i_req(mem_req), .o_rdata(rdata));

    uc_engine ENGINE (.i_clk, .i_rst_n, .i_run, .i_rdata(rdata), .i_dev_rdata(dev_rdata),
        .i_d0(d0), .i_d1(d1), .i_r0(r0), .i_alu_result(alu_result), .o_pc(pc),
        .o_mem_req(mem_req), .o_dev_req(dev_req), .o_d_value(d_value),
        .o_r_value(r_value), .o_d_op(d_op), .o_r_op(r_op), .o_alu_op(alu_op),
        .o_sel_a(sel_a), .o_sel_b(sel_b), .o_running, .o_status);

    stack_lifo #(.DEPTH(STACK_DEPTH)) D_STACK (.i_clk, .i_rst_n, .i_value(d_value),
        .i_op(d_op), .o_s0(d0), .o_s1(d1));

    // return second is not needed by the ALU
    stack_lifo #(.DEPTH(STACK_DEPTH)) R_STACK (.i_clk, .i_rst_n, .i_value(r_value),
        .i_op(r_op), .o_s0(r0), .o_s1());

    alu ALU (.i_op(alu_op), .i_sel_a(sel_a), .i_sel_b(sel_b), .i_d0(d0), .i_d1(d1),
        .i_r0(r0), .o_result(alu_result));

    dev_port DEV (.i_clk, .i_rst_n, .i_req(dev_req), .i_in_data, .o_rdata(dev_rdata),
        .o_out_valid, .o_out_data);

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int NT       = 8;                    // table entries
    localparam int MAX_PROG = 24;
    localparam int MAX_OUT  = 8;
    localparam int TIMEOUT  = 2000;                 // cycles per wait

    // hand-assembled opcodes
    localparam word_t OP_LIT   = 16'h021F;          // [pc] literal push
    localparam word_t OP_PUSH0 = 16'h02C0;
    localparam word_t OP_PUSH1 = 16'h02D1;
    localparam word_t OP_OUT   = 16'h09BF;          // ( value reg -- )
    localparam word_t OP_DEVRD = 16'h033F;          // ( reg -- value )
    localparam word_t OP_STORE = 16'h098F;          // ( value addr -- )
    localparam word_t OP_FETCH = 16'h030F;          // ( addr -- value )
    localparam word_t OP_FAIL  = 16'h002F;
    localparam word_t OP_ADD   = 16'h0741;
    localparam word_t OP_SUB   = 16'h0742;
    localparam word_t OP_AND   = 16'h0744;
    localparam word_t OP_XOR   = 16'h0745;
    localparam word_t OP_OR    = 16'h0746;
    localparam word_t OP_INC   = 16'h0311;
    localparam word_t OP_DEC   = 16'h0331;
    localparam word_t OP_NEG   = 16'h03C2;
    localparam word_t OP_INV   = 16'h0335;
    localparam word_t OP_ROL   = 16'h0307;
    localparam word_t OP_DUP   = 16'h0200;
    localparam word_t OP_DROP  = 16'h0100;
    localparam word_t OP_SWAP  = 16'h0400;
    localparam word_t OP_ROT   = 16'h0500;
    localparam word_t OP_OVER  = 16'h0600;
    localparam word_t OP_TOR   = 16'h2100;          // >R
    localparam word_t OP_RFROM = 16'h1280;          // R>
    localparam word_t OP_RFET  = 16'h0280;          // R@
    localparam word_t OP_RET   = 16'h5000;
    localparam word_t OP_JMP   = 16'h8000;          // low 11 bits are the target
    localparam word_t OP_CALL  = 16'hC000;
    localparam word_t OP_BZ    = 16'hA000;
    localparam word_t OP_CDB   = 16'hB000;

    logic   i_clk = 1'b0;
    logic   i_rst_n;
    logic   i_run;
    logic   i_load;
    uaddr_t i_load_addr;
    word_t  i_load_data;
    word_t  i_in_data;
    logic   o_running;
    logic   o_status;
    logic   o_out_valid;
    word_t  o_out_data;

    string t_name [NT];
    word_t t_prog [NT][MAX_PROG];
    int    t_len  [NT];
    int    t_cnt  [NT];
    word_t t_out  [NT][MAX_OUT];
    logic  t_stat [NT];
    word_t t_in   [NT];
    int    n_tests = 0;
    int    cur;

    cpu_top UUT (.i_clk, .i_rst_n, .i_run, .i_load, .i_load_addr, .i_load_data,
        .i_in_data, .o_running, .o_status, .o_out_valid, .o_out_data);

    always #50 i_clk = ~i_clk;                      // 100 ns period

    task automatic check(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic new_test(input string nm, input logic st, input word_t din);
        cur = n_tests;
        n_tests++;
        t_name[cur] = nm;
        t_stat[cur] = st;
        t_in[cur]   = din;
    endtask

    task automatic asm(input word_t w);
        t_prog[cur][t_len[cur]] = w;
        t_len[cur]++;
    endtask

    task automatic lit(input word_t v);
        asm(OP_LIT);
        asm(v);                                     // inline word, skipped by pc
    endtask

    task automatic emit_top();
        asm(OP_PUSH0);                              // output register id
        asm(OP_OUT);
    endtask

    task automatic halt_here();
        asm(OP_JMP | word_t'(t_len[cur]));          // jump to itself
    endtask

    task automatic expect_out(input word_t v);
        t_out[cur][t_cnt[cur]] = v;
        t_cnt[cur]++;
    endtask

    task automatic build_table();
        word_t a;
        word_t b;
        word_t m;
        word_t v;
        word_t w;
        word_t din;
        word_t n;
        a   = word_t'($urandom);
        b   = word_t'($urandom);
        if (b == a) b = ~a;
        m   = 16'h0400 | (word_t'($urandom) & 16'h03FF);  // clear of the programs
        v   = word_t'($urandom);
        w   = word_t'($urandom);
        din = word_t'($urandom);
        n   = 16'd2 + word_t'($urandom % 5);

        new_test("alu_bin_a", 1'b1, '0);
        lit(a); lit(b);
        asm(OP_OVER); asm(OP_OVER); asm(OP_ADD); emit_top(); expect_out(a + b);
        asm(OP_OVER); asm(OP_OVER); asm(OP_SUB); emit_top(); expect_out(a - b);
        asm(OP_OVER); asm(OP_OVER); asm(OP_AND); emit_top(); expect_out(a & b);
        halt_here();

        new_test("alu_bin_b", 1'b1, '0);
        lit(a); lit(b);
        asm(OP_OVER); asm(OP_OVER); asm(OP_XOR); emit_top(); expect_out(a ^ b);
        asm(OP_OVER); asm(OP_OVER); asm(OP_OR); emit_top(); expect_out(a | b);
        halt_here();

        new_test("alu_unary", 1'b1, '0);
        lit(a);
        asm(OP_DUP); asm(OP_INC); emit_top(); expect_out(a + 16'd1);
        asm(OP_DUP); asm(OP_DEC); emit_top(); expect_out(a - 16'd1);
        asm(OP_DUP); asm(OP_NEG); emit_top(); expect_out(16'd0 - a);
        asm(OP_DUP); asm(OP_INV); emit_top(); expect_out(~a);
        asm(OP_DUP); asm(OP_ROL); emit_top(); expect_out({a[14:0], a[15]});
        halt_here();

        // ( a b ) over emit >R R@ emit dup R> rot drop swap emit emit
        new_test("stack", 1'b1, '0);
        lit(a); lit(b);
        asm(OP_OVER); emit_top(); expect_out(a);
        asm(OP_TOR); asm(OP_RFET); emit_top(); expect_out(b);
        asm(OP_DUP); asm(OP_RFROM); asm(OP_ROT); asm(OP_DROP); asm(OP_SWAP);
        emit_top(); expect_out(a);
        emit_top(); expect_out(b);
        halt_here();

        new_test("branch", 1'b1, '0);
        asm(OP_PUSH1); asm(OP_BZ | 16'd8);         // 0..1 not taken
        lit(a); emit_top(); expect_out(a);          // 2..5
        asm(OP_PUSH0); asm(OP_BZ | 16'd12);        // 6..7 taken
        lit(~a); emit_top();                        // 8..11 skipped
        asm(OP_CALL | 16'd14);                      // 12
        halt_here();                                // 13
        lit(b); emit_top(); expect_out(b);          // 14..17 procedure
        asm(OP_RET);                                // 18

        new_test("countdown", 1'b1, '0);
        lit(n);                                     // 0..1
        asm(OP_DUP); emit_top();                    // 2..4 loop body
        asm(OP_CDB | 16'd7); asm(OP_JMP | 16'd2);   // 5..6
        halt_here();                                // 7
        for (int k = int'(n); k >= 0; k--) expect_out(word_t'(k));

        new_test("memory", 1'b1, '0);
        lit(v); lit(m); asm(OP_STORE);
        lit(m); asm(OP_FETCH); emit_top(); expect_out(v);
        lit(w); emit_top(); expect_out(w);
        halt_here();

        new_test("device_fail", 1'b0, din);
        asm(OP_PUSH1); asm(OP_DEVRD); emit_top(); expect_out(din);
        asm(OP_FAIL);
        lit(a); emit_top();                         // never reached
        halt_here();
    endtask

    task automatic reset_dut(input word_t din);
        @(posedge i_clk);
        i_rst_n   <= 1'b0;
        i_run     <= 1'b0;
        i_in_data <= din;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
    endtask

    task automatic load_and_start(input int idx);
        for (int i = 0; i < t_len[idx]; i++) begin
            @(posedge i_clk);
            i_load      <= 1'b1;
            i_load_addr <= uaddr_t'(i);
            i_load_data <= t_prog[idx][i];
        end
        @(posedge i_clk);
        i_load <= 1'b0;
        i_run  <= 1'b1;
    endtask

    task automatic wait_out(input string name, output word_t data);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge i_clk);
            seen = o_out_valid;
            n++;
        end
        if (!seen) abort_run({"timeout waiting for an output strobe in ", name});
        data = o_out_data;
    endtask

    task automatic wait_stop(input string name);
        int n;
        n = 0;
        while (o_running && n < TIMEOUT) begin
            @(negedge i_clk);
            n++;
        end
        if (o_running) abort_run({"timeout waiting for the processor to stop in ", name});
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge i_clk);
            if (o_out_valid) abort_run({"unexpected extra output strobe in ", name});
        end
    endtask

    task automatic run_entry(input int idx);
        word_t got;
        reset_dut(t_in[idx]);
        load_and_start(idx);
        for (int k = 0; k < t_cnt[idx]; k++) begin
            wait_out(t_name[idx], got);
            check($sformatf("%s out[%0d]", t_name[idx], k), t_out[idx][k], got);
        end
        if (!t_stat[idx]) wait_stop(t_name[idx]);
        expect_quiet(t_name[idx], 40);
        check({t_name[idx], " running"}, word_t'(t_stat[idx]), word_t'(o_running));
        @(posedge i_clk);
        i_run <= 1'b0;
        @(negedge i_clk);
        check({t_name[idx], " status"}, word_t'(t_stat[idx]), word_t'(o_status));
        check({t_name[idx], " stopped"}, 16'h0000, word_t'(o_running));  // run low
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_run       = 1'b0;
        i_load      = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_in_data   = '0;
        void'($urandom(32'hfd60_8ac5));
        build_table();
        for (int t = 0; t < n_tests; t++) begin
            run_entry(t);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
cpu_pkg.sv
ucode_mem.sv
stack_lifo.sv
alu.sv
uc_engine.sv
dev_port.sv
cpu_top.sv
tb_cpu.sv
